// File: huff_pkg.sv
`default_nettype none

package huff_pkg;

  // alphabet and buffer sizing
  localparam int SYM_COUNT = 16;
  localparam int SYM_W     = 4;
  localparam int BUF_DEPTH = 32;
  localparam int ADDR_W    = 5;
  localparam int BCNT_W    = 6;

  // 64 symbols at most, so 7 bits hold any single count or total weight
  localparam int CNT_W     = 7;
  localparam int LEN_W     = 4;
  localparam int CODE_W    = 9;

  typedef logic [SYM_W-1:0] sym_t;

  typedef struct packed {
    sym_t hi_nib;
    sym_t lo_nib;
  } nib_pair_t;

  // one stored byte, seen raw by the packer and as two symbols downstream
  typedef union packed {
    logic [7:0] raw;
    nib_pair_t  nib;
  } huff_byte_u;

  typedef struct packed {
    logic [LEN_W-1:0]  len;
    logic [CODE_W-1:0] code;
  } code_entry_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } buf_rd_t;

  typedef struct packed {
    logic [BCNT_W-1:0] byte_count;
    logic              eof;
  } stream_info_t;

  typedef logic [SYM_COUNT-1:0][CNT_W-1:0] count_vec_t;
  typedef logic [SYM_COUNT-1:0][LEN_W-1:0] len_vec_t;
  typedef code_entry_t [SYM_COUNT-1:0]     book_t;

endpackage

`default_nettype wire

// File: chunk_packer.sv
`timescale 1ns/10ps
`default_nettype none

module chunk_packer (
  input  wire logic           hwclk,
  input  wire logic           reset,
  input  wire logic           chunk_valid_i,
  input  wire logic [6:0]     chunk_i,
  input  wire logic           eof_i,
  output logic                byte_valid_o,
  output huff_pkg::huff_byte_u byte_data_o,
  output logic                input_done_o
);

  logic [13:0] acc_q;
  logic [3:0]  fill_q;
  logic        closed_q;
  logic [13:0] acc_merged;
  logic [4:0]  fill_sum;

  // new chunk lands above the bits already held
  always_comb begin
    acc_merged = acc_q | ({7'd0, chunk_i} << fill_q);
    fill_sum   = {1'b0, fill_q} + 5'd7;
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      acc_q        <= '0;
      fill_q       <= '0;
      closed_q     <= 1'b0;
      byte_valid_o <= 1'b0;
      input_done_o <= 1'b0;
    end else begin
      byte_valid_o <= 1'b0;
      input_done_o <= 1'b0;
      // one stream per reset, later chunks are ignored
      if (!closed_q) begin
        if (chunk_valid_i) begin
          if (fill_sum >= 5'd8) begin
            byte_valid_o <= 1'b1;
            acc_q        <= acc_merged >> 8;
            fill_q       <= fill_sum[3:0] - 4'd8;
          end else begin
            acc_q  <= acc_merged;
            fill_q <= fill_sum[3:0];
          end
        end
        // leftover partial byte is thrown away
        if (eof_i) begin
          acc_q        <= '0;
          fill_q       <= '0;
          closed_q     <= 1'b1;
          input_done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (chunk_valid_i) begin
      byte_data_o.raw <= acc_merged[7:0];
    end
  end

endmodule

`default_nettype wire

// File: symbol_store.sv
`timescale 1ns/10ps
`default_nettype none

module symbol_store (
  input  wire logic                 hwclk,
  input  wire logic                 reset,
  input  wire logic                 byte_valid_i,
  input  wire huff_pkg::huff_byte_u byte_data_i,
  input  wire logic                 input_done_i,
  input  wire huff_pkg::buf_rd_t    rd_i,
  output huff_pkg::huff_byte_u      rd_data_o,
  output huff_pkg::count_vec_t      counts_o,
  output huff_pkg::stream_info_t    info_o,
  output logic                      hist_done_o
);

  huff_pkg::huff_byte_u mem [huff_pkg::BUF_DEPTH];

  logic [huff_pkg::BCNT_W-1:0] wr_cnt_q;
  logic                        eof_q;
  logic                        store_en;

  // buffer full means the byte is dropped entirely, counts included
  assign store_en = byte_valid_i && !eof_q && (wr_cnt_q < huff_pkg::BUF_DEPTH);

  assign info_o = '{byte_count: wr_cnt_q, eof: eof_q};

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      wr_cnt_q    <= '0;
      eof_q       <= 1'b0;
      hist_done_o <= 1'b0;
      counts_o    <= '0;
    end else begin
      hist_done_o <= input_done_i;
      if (input_done_i) begin
        eof_q <= 1'b1;
      end
      if (store_en) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
        // both nibbles count, twice when they match
        for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
          counts_o[s] <= counts_o[s]
                         + (byte_data_i.nib.hi_nib == huff_pkg::sym_t'(s))
                         + (byte_data_i.nib.lo_nib == huff_pkg::sym_t'(s));
        end
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (store_en) begin
      mem[wr_cnt_q[huff_pkg::ADDR_W-1:0]] <= byte_data_i;
    end
    // read data valid the cycle after the address
    rd_data_o <= mem[rd_i.addr];
  end

endmodule

`default_nettype wire

// File: code_length_builder.sv
`timescale 1ns/10ps
`default_nettype none

module code_length_builder (
  input  wire logic                 hwclk,
  input  wire logic                 reset,
  input  wire logic                 start_i,
  input  wire huff_pkg::count_vec_t counts_i,
  output huff_pkg::len_vec_t        lengths_o,
  output logic                      done_o
);

  typedef enum logic [2:0] {
    B_IDLE,
    B_CHECK,
    B_SCAN1,
    B_SCAN2,
    B_MERGE,
    B_FIX
  } state_t;

  state_t state_q;

  // weight and liveness are kept per group id, membership per symbol
  logic [huff_pkg::CNT_W-1:0]     grp_w [huff_pkg::SYM_COUNT];
  logic [huff_pkg::SYM_COUNT-1:0] grp_act;
  huff_pkg::sym_t                 grp_id [huff_pkg::SYM_COUNT];

  huff_pkg::sym_t             idx_q;
  huff_pkg::sym_t             pick_a_q;
  huff_pkg::sym_t             pick_b_q;
  huff_pkg::sym_t             best_id_q;
  logic [huff_pkg::CNT_W-1:0] best_w_q;
  logic                       best_ok_q;
  logic [huff_pkg::SYM_W:0]   groups_q;
  logic [huff_pkg::SYM_W:0]   n_init;
  logic                       take;
  huff_pkg::sym_t             nxt_id;
  huff_pkg::sym_t             lo_id;
  huff_pkg::sym_t             hi_id;

  always_comb begin
    n_init = '0;
    for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
      n_init = n_init + (counts_i[s] != '0);
    end
    // strict less-than keeps the lowest id on equal weights
    take = grp_act[idx_q] && !(state_q == B_SCAN2 && idx_q == pick_a_q)
           && (!best_ok_q || grp_w[idx_q] < best_w_q);
    nxt_id = take ? idx_q : best_id_q;
    lo_id  = (pick_a_q < pick_b_q) ? pick_a_q : pick_b_q;
    hi_id  = (pick_a_q < pick_b_q) ? pick_b_q : pick_a_q;
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state_q   <= B_IDLE;
      idx_q     <= '0;
      pick_a_q  <= '0;
      pick_b_q  <= '0;
      best_id_q <= '0;
      best_w_q  <= '0;
      best_ok_q <= 1'b0;
      groups_q  <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        B_IDLE: begin
          if (start_i) begin
            groups_q <= n_init;
            state_q  <= B_CHECK;
          end
        end
        B_CHECK: begin
          idx_q     <= '0;
          best_ok_q <= 1'b0;
          state_q   <= (groups_q > 1) ? B_SCAN1 : B_FIX;
        end
        B_SCAN1, B_SCAN2: begin
          if (take) begin
            best_id_q <= idx_q;
            best_w_q  <= grp_w[idx_q];
            best_ok_q <= 1'b1;
          end
          idx_q <= idx_q + 1'b1;
          // last symbol index closes the scan
          if (&idx_q) begin
            best_ok_q <= 1'b0;
            if (state_q == B_SCAN1) begin
              pick_a_q <= nxt_id;
              state_q  <= B_SCAN2;
            end else begin
              pick_b_q <= nxt_id;
              state_q  <= B_MERGE;
            end
          end
        end
        B_MERGE: begin
          groups_q <= groups_q - 1'b1;
          state_q  <= B_CHECK;
        end
        default: begin
          done_o  <= 1'b1;
          state_q <= B_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge hwclk) begin
    if (state_q == B_IDLE && start_i) begin
      for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
        grp_w[s]     <= counts_i[s];
        grp_act[s]   <= (counts_i[s] != '0);
        grp_id[s]    <= huff_pkg::sym_t'(s);
        lengths_o[s] <= '0;
      end
    end else if (state_q == B_MERGE) begin
      grp_w[lo_id]   <= grp_w[pick_a_q] + grp_w[pick_b_q];
      grp_act[hi_id] <= 1'b0;
      for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
        if (grp_id[s] == pick_a_q || grp_id[s] == pick_b_q) begin
          grp_id[s]    <= lo_id;
          lengths_o[s] <= lengths_o[s] + 1'b1;
        end
      end
    end else if (state_q == B_FIX) begin
      // a lone active symbol still needs one bit
      for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
        if (counts_i[s] != '0 && lengths_o[s] == '0) begin
          lengths_o[s] <= 'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: canonical_codebook.sv
`timescale 1ns/10ps
`default_nettype none

module canonical_codebook (
  input  wire logic               hwclk,
  input  wire logic               reset,
  input  wire logic               start_i,
  input  wire huff_pkg::len_vec_t lengths_i,
  output huff_pkg::book_t         book_o,
  output logic                    done_o
);

  logic                        walking_q;
  logic [huff_pkg::LEN_W-1:0]  cur_len_q;
  huff_pkg::sym_t              idx_q;
  logic [huff_pkg::CODE_W-1:0] code_q;
  logic [huff_pkg::CODE_W-1:0] code_nxt;
  logic                        hit;

  assign hit      = walking_q && (lengths_i[idx_q] == cur_len_q);
  assign code_nxt = hit ? code_q + 1'b1 : code_q;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      walking_q <= 1'b0;
      cur_len_q <= '0;
      idx_q     <= '0;
      code_q    <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !walking_q) begin
        walking_q <= 1'b1;
        cur_len_q <= 'd1;
        idx_q     <= '0;
        code_q    <= '0;
      end else if (walking_q) begin
        idx_q <= idx_q + 1'b1;
        if (&idx_q) begin
          // one length step is one left shift
          code_q <= code_nxt << 1;
          if (cur_len_q == huff_pkg::CODE_W) begin
            walking_q <= 1'b0;
            done_o    <= 1'b1;
          end else begin
            cur_len_q <= cur_len_q + 1'b1;
          end
        end else begin
          code_q <= code_nxt;
        end
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (start_i && !walking_q) begin
      for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
        book_o[s].len  <= lengths_i[s];
        book_o[s].code <= '0;
      end
    end else if (hit) begin
      book_o[idx_q].code <= code_q;
    end
  end

endmodule

`default_nettype wire

// File: bit_emitter.sv
`timescale 1ns/10ps
`default_nettype none

module bit_emitter (
  input  wire logic                   hwclk,
  input  wire logic                   reset,
  input  wire logic                   start_i,
  input  wire huff_pkg::book_t        book_i,
  input  wire huff_pkg::stream_info_t info_i,
  output huff_pkg::buf_rd_t           rd_o,
  input  wire huff_pkg::huff_byte_u   rd_data_i,
  output logic                        bit_req_o,
  output logic                        bit_o,
  input  wire logic                   bit_ack_i,
  output logic                        done_o
);

  typedef enum logic [3:0] {
    E_IDLE,
    E_HDR,
    E_RD,
    E_NIB,
    E_DBIT,
    E_REQ,
    E_ACK,
    E_REL,
    E_NEXT,
    E_DONE
  } state_t;

  state_t                      state_q;
  logic                        in_data_q;
  logic [5:0]                  hdr_cnt_q;
  logic [huff_pkg::ADDR_W-1:0] byte_idx_q;
  logic                        nib_lo_q;
  logic [huff_pkg::LEN_W-1:0]  pos_q;
  huff_pkg::sym_t              sym;
  huff_pkg::code_entry_t       entry;
  logic [huff_pkg::LEN_W-1:0]  hdr_len;
  logic                        last_byte;

  assign rd_o      = '{addr: byte_idx_q};
  assign sym       = nib_lo_q ? rd_data_i.nib.lo_nib : rd_data_i.nib.hi_nib;
  assign entry     = book_i[sym];
  // four header bits per symbol
  assign hdr_len   = book_i[hdr_cnt_q[5:2]].len;
  assign last_byte = ({1'b0, byte_idx_q} == info_i.byte_count - 1'b1);

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state_q    <= E_IDLE;
      in_data_q  <= 1'b0;
      hdr_cnt_q  <= '0;
      byte_idx_q <= '0;
      nib_lo_q   <= 1'b0;
      pos_q      <= '0;
      bit_req_o  <= 1'b0;
      bit_o      <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      case (state_q)
        E_IDLE: begin
          if (start_i && info_i.eof) begin
            hdr_cnt_q <= '0;
            in_data_q <= 1'b0;
            state_q   <= E_HDR;
          end
        end
        E_HDR: begin
          // MSB of each length first
          bit_o   <= hdr_len[~hdr_cnt_q[1:0]];
          state_q <= E_REQ;
        end
        E_RD: state_q <= E_NIB;
        E_NIB: begin
          if (entry.len == '0) begin
            state_q <= E_NEXT;
          end else begin
            pos_q   <= entry.len - 1'b1;
            state_q <= E_DBIT;
          end
        end
        E_DBIT: begin
          bit_o   <= entry.code[pos_q];
          state_q <= E_REQ;
        end
        // bit_o is already stable here
        E_REQ: begin
          bit_req_o <= 1'b1;
          state_q   <= E_ACK;
        end
        E_ACK: begin
          if (bit_ack_i) begin
            bit_req_o <= 1'b0;
            state_q   <= E_REL;
          end
        end
        E_REL: begin
          if (!bit_ack_i) begin
            if (!in_data_q) begin
              if (&hdr_cnt_q) begin
                in_data_q  <= 1'b1;
                byte_idx_q <= '0;
                nib_lo_q   <= 1'b0;
                state_q    <= (info_i.byte_count == '0) ? E_DONE : E_RD;
              end else begin
                hdr_cnt_q <= hdr_cnt_q + 1'b1;
                state_q   <= E_HDR;
              end
            end else if (pos_q != '0) begin
              pos_q   <= pos_q - 1'b1;
              state_q <= E_DBIT;
            end else begin
              state_q <= E_NEXT;
            end
          end
        end
        E_NEXT: begin
          if (!nib_lo_q) begin
            nib_lo_q <= 1'b1;
            state_q  <= E_NIB;
          end else if (last_byte) begin
            state_q <= E_DONE;
          end else begin
            byte_idx_q <= byte_idx_q + 1'b1;
            nib_lo_q   <= 1'b0;
            state_q    <= E_RD;
          end
        end
        default: done_o <= 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: huff_compress_top.sv
`timescale 1ns/10ps
`default_nettype none

module huff_compress_top (
  input  wire logic       hwclk,
  input  wire logic       reset,
  input  wire logic       chunk_valid_i,
  input  wire logic [6:0] chunk_i,
  input  wire logic       eof_i,
  input  wire logic       bit_ack_i,
  output logic            bit_req_o,
  output logic            bit_o,
  output logic            busy_o,
  output logic            done_o
);

  logic                   byte_valid;
  huff_pkg::huff_byte_u   byte_data;
  logic                   input_done;
  huff_pkg::buf_rd_t      rd;
  huff_pkg::huff_byte_u   rd_data;
  huff_pkg::count_vec_t   counts;
  huff_pkg::stream_info_t info;
  logic                   hist_done;
  huff_pkg::len_vec_t     lengths;
  logic                   len_done;
  huff_pkg::book_t        book;
  logic                   book_done;
  logic                   busy_q;

  // decode
  chunk_packer i_chunk_packer (
    .hwclk        (hwclk),
    .reset        (reset),
    .chunk_valid_i(chunk_valid_i),
    .chunk_i      (chunk_i),
    .eof_i        (eof_i),
    .byte_valid_o (byte_valid),
    .byte_data_o  (byte_data),
    .input_done_o (input_done)
  );

  // execute
  symbol_store i_symbol_store (
    .hwclk       (hwclk),
    .reset       (reset),
    .byte_valid_i(byte_valid),
    .byte_data_i (byte_data),
    .input_done_i(input_done),
    .rd_i        (rd),
    .rd_data_o   (rd_data),
    .counts_o    (counts),
    .info_o      (info),
    .hist_done_o (hist_done)
  );

  code_length_builder i_code_length_builder (
    .hwclk    (hwclk),
    .reset    (reset),
    .start_i  (hist_done),
    .counts_i (counts),
    .lengths_o(lengths),
    .done_o   (len_done)
  );

  canonical_codebook i_canonical_codebook (
    .hwclk    (hwclk),
    .reset    (reset),
    .start_i  (len_done),
    .lengths_i(lengths),
    .book_o   (book),
    .done_o   (book_done)
  );

  // result
  bit_emitter i_bit_emitter (
    .hwclk    (hwclk),
    .reset    (reset),
    .start_i  (book_done),
    .book_i   (book),
    .info_i   (info),
    .rd_o     (rd),
    .rd_data_i(rd_data),
    .bit_req_o(bit_req_o),
    .bit_o    (bit_o),
    .bit_ack_i(bit_ack_i),
    .done_o   (done_o)
  );

  // busy from first chunk until the stream is out
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      busy_q <= 1'b0;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end else if (chunk_valid_i) begin
      busy_q <= 1'b1;
    end
  end

  assign busy_o = busy_q & ~done_o;

endmodule

`default_nettype wire

// File: tb_huff_model.svh
`ifndef TB_HUFF_MODEL_SVH
`define TB_HUFF_MODEL_SVH

// expected stream for one case, rebuilt from its chunk list
logic [7:0] m_bytes [huff_pkg::BUF_DEPTH];
int         m_nbytes;
int         m_count [huff_pkg::SYM_COUNT];
int         m_len [huff_pkg::SYM_COUNT];
int         m_code [huff_pkg::SYM_COUNT];
int         grp_weight [huff_pkg::SYM_COUNT];
bit         grp_live [huff_pkg::SYM_COUNT];
int         grp_of [huff_pkg::SYM_COUNT];
bit         exp_bits [$];

// chunk stream is LSB first, bit j sits in chunk j/7 at position j%7
task automatic pack_bytes(input int c);
  int j;
  m_nbytes = (table_n[c] * 7) / 8;
  if (m_nbytes > huff_pkg::BUF_DEPTH) begin
    m_nbytes = huff_pkg::BUF_DEPTH;
  end
  for (int k = 0; k < m_nbytes; k++) begin
    for (int b = 0; b < 8; b++) begin
      j = 8 * k + b;
      m_bytes[k][b] = table_chunks[c][j / 7][j % 7];
    end
  end
endtask

task automatic count_symbols();
  for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
    m_count[s] = 0;
  end
  for (int k = 0; k < m_nbytes; k++) begin
    m_count[m_bytes[k][7:4]]++;
    m_count[m_bytes[k][3:0]]++;
  end
endtask

// lightest live group, lowest id on a tie
function automatic int least_group(input int skip);
  int best;
  best = -1;
  for (int g = 0; g < huff_pkg::SYM_COUNT; g++) begin
    if (grp_live[g] && g != skip) begin
      if (best < 0 || grp_weight[g] < grp_weight[best]) begin
        best = g;
      end
    end
  end
  return best;
endfunction

task automatic build_lengths();
  int groups;
  int a;
  int b;
  int lo;
  int hi;
  groups = 0;
  for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
    grp_weight[s] = m_count[s];
    grp_live[s]   = (m_count[s] != 0);
    grp_of[s]     = s;
    m_len[s]      = 0;
    if (m_count[s] != 0) begin
      groups++;
    end
  end
  while (groups > 1) begin
    a  = least_group(-1);
    b  = least_group(a);
    lo = (a < b) ? a : b;
    hi = (a < b) ? b : a;
    grp_weight[lo] = grp_weight[a] + grp_weight[b];
    grp_live[hi]   = 1'b0;
    for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
      if (grp_of[s] == a || grp_of[s] == b) begin
        grp_of[s] = lo;
        m_len[s]++;
      end
    end
    groups--;
  end
  // lone symbol
  for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
    if (m_count[s] != 0 && m_len[s] == 0) begin
      m_len[s] = 1;
    end
  end
endtask

// ordered by length then index, code grows by one and shifts with length
task automatic assign_codes();
  int code;
  int prev_len;
  bit first;
  code     = 0;
  prev_len = 0;
  first    = 1'b1;
  for (int l = 1; l <= huff_pkg::CODE_W; l++) begin
    for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
      if (m_len[s] == l) begin
        if (!first) begin
          code = (code + 1) << (l - prev_len);
        end
        first     = 1'b0;
        m_code[s] = code;
        prev_len  = l;
      end
    end
  end
endtask

task automatic build_expected(input int c);
  pack_bytes(c);
  count_symbols();
  build_lengths();
  assign_codes();
  exp_bits.delete();
  for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
    for (int b = 3; b >= 0; b--) begin
      exp_bits.push_back(m_len[s][b]);
    end
  end
  for (int k = 0; k < m_nbytes; k++) begin
    for (int b = m_len[m_bytes[k][7:4]] - 1; b >= 0; b--) begin
      exp_bits.push_back(m_code[m_bytes[k][7:4]][b]);
    end
    for (int b = m_len[m_bytes[k][3:0]] - 1; b >= 0; b--) begin
      exp_bits.push_back(m_code[m_bytes[k][3:0]][b]);
    end
  end
endtask

`endif

// File: tb_huff_compress.sv
`timescale 1ns/10ps
`default_nettype none

module tb_huff_compress;

  localparam int N_CASES    = 7;
  localparam int MAX_CHUNKS = 40;

  logic       hwclk;
  logic       reset;
  logic       chunk_valid;
  logic [6:0] chunk;
  logic       eof;
  logic       bit_ack;
  logic       bit_req;
  logic       bit_out;
  logic       busy;
  logic       done;

  int         seed = 47660;
  int         cycles = 0;
  int         cycle_limit;
  int         error_count = 0;
  logic       req_prev = 1'b0;
  logic       bit_held = 1'b0;

  // stimulus table with one row per case
  logic [6:0] table_chunks [N_CASES][MAX_CHUNKS];
  int         table_n [N_CASES];
  int         table_delay [N_CASES];

  `include "tb_huff_model.svh"

  huff_compress_top i_huff_compress_top (
    .hwclk        (hwclk),
    .reset        (reset),
    .chunk_valid_i(chunk_valid),
    .chunk_i      (chunk),
    .eof_i        (eof),
    .bit_ack_i    (bit_ack),
    .bit_req_o    (bit_req),
    .bit_o        (bit_out),
    .busy_o       (busy),
    .done_o       (done)
  );

  initial begin
    hwclk = 1'b0;
    forever #4 hwclk = ~hwclk;
  end

  task automatic stop_on_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_value(input int got, input int want, input string what);
    if (got != want) begin
      error_count++;
      $display("error at %0t ns: %s, got %0d expected %0d", $time, what, got, want);
      stop_on_failure();
    end
  endtask

  // chunk 0 sits in the low 7 bits of vals
  task automatic load_case(input int c, input int n, input int dly, input logic [55:0] vals);
    table_n[c]     = n;
    table_delay[c] = dly;
    for (int i = 0; i < MAX_CHUNKS; i++) begin
      table_chunks[c][i] = (i < 8) ? vals[7*i +: 7] : 7'd0;
    end
  endtask

  task automatic load_random_case(input int c, input int n, input int dly);
    table_n[c]     = n;
    table_delay[c] = dly;
    for (int i = 0; i < MAX_CHUNKS; i++) begin
      table_chunks[c][i] = 7'($random(seed));
    end
  endtask

  task automatic fill_table();
    load_case(0, 8, 0, {7'h58, 7'h2c, 7'h40, 7'h7f, 7'h01, 7'h33, 7'h6a, 7'h15});
    load_case(1, 7, 3, {7'h00, 7'h01, 7'h66, 7'h3c, 7'h5b, 7'h12, 7'h70, 7'h0f});
    load_case(2, 0, 1, 56'd0);
    load_case(3, 4, 2, {28'd0, 7'h7f, 7'h7f, 7'h7f, 7'h7f});
    // bytes 0x10, 0x32 and 0x54 give six symbols of equal weight
    load_case(4, 4, 0, {28'd0, 7'h7a, 7'h50, 7'h64, 7'h10});
    load_random_case(5, 40, 5);
    load_random_case(6, 20, 2);
  endtask

  // build and codebook passes plus per bit handshake and per byte fetch
  function automatic int cycle_budget();
    int total;
    int bytes;
    int bits;
    total = 0;
    for (int c = 0; c < N_CASES; c++) begin
      bytes = (table_n[c] * 7) / 8;
      if (bytes > huff_pkg::BUF_DEPTH) begin
        bytes = huff_pkg::BUF_DEPTH;
      end
      bits  = 4 * huff_pkg::SYM_COUNT + 2 * bytes * huff_pkg::CODE_W;
      total = total + 800 + table_n[c] + bits * (table_delay[c] + 10) + 5 * bytes;
    end
    return total;
  endfunction

  task automatic apply_reset();
    @(posedge hwclk);
    reset   <= 1'b1;
    bit_ack <= 1'b0;
    repeat (2) @(posedge hwclk);
    reset <= 1'b0;
    @(posedge hwclk);
    check_value(bit_req, 0, "bit_req_o high after reset");
    check_value(busy, 0, "busy_o high after reset");
    check_value(done, 0, "done_o high after reset");
  endtask

  task automatic send_chunks(input int c, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge hwclk);
      chunk_valid <= 1'b1;
      chunk       <= table_chunks[c][i % MAX_CHUNKS];
    end
    @(posedge hwclk);
    chunk_valid <= 1'b0;
    eof         <= 1'b1;
    @(posedge hwclk);
    eof <= 1'b0;
  endtask

  task automatic collect_stream(input int c);
    int rx_count;
    int dly;
    rx_count = 0;
    while (!done) begin
      @(posedge hwclk);
      if (bit_req && !bit_ack) begin
        if (table_n[c] > 0) begin
          check_value(busy, 1, "busy_o low during stream");
        end
        dly = $unsigned($random(seed)) % (table_delay[c] + 1);
        repeat (dly) @(posedge hwclk);
        check_value(int'(rx_count < exp_bits.size()), 1,
                    $sformatf("case %0d extra bit beyond expected stream", c));
        check_value(int'(bit_out), int'(exp_bits[rx_count]),
                    $sformatf("case %0d bit %0d", c, rx_count));
        rx_count++;
        bit_ack <= 1'b1;
        @(posedge hwclk);
        while (bit_req) begin
          @(posedge hwclk);
        end
        bit_ack <= 1'b0;
      end
    end
    check_value(rx_count, exp_bits.size(), $sformatf("case %0d stream length", c));
  endtask

  // a finished stream ignores new input and keeps done_o
  task automatic check_idle_after_done(input int c);
    send_chunks(c, 3);
    repeat (12) begin
      @(posedge hwclk);
      check_value(bit_req, 0, "bit_req_o raised after done_o");
      check_value(done, 1, "done_o dropped after stream");
      check_value(busy, 0, "busy_o high after done_o");
    end
  endtask

  // bit_o must hold for the whole request phase
  always @(posedge hwclk) begin
    if (bit_req && req_prev) begin
      check_value(int'(bit_out), int'(bit_held), "bit_o changed while bit_req_o high");
    end
    req_prev <= bit_req;
    bit_held <= bit_out;
  end

  always @(posedge hwclk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout, the stream did not finish within %0d cycles", cycle_limit);
      stop_on_failure();
    end
  end

  initial begin
    reset       = 1'b1;
    chunk_valid = 1'b0;
    chunk       = 7'd0;
    eof         = 1'b0;
    bit_ack     = 1'b0;
    fill_table();
    cycle_limit = cycle_budget();
    for (int c = 0; c < N_CASES; c++) begin
      apply_reset();
      build_expected(c);
      send_chunks(c, table_n[c]);
      collect_stream(c);
      check_idle_after_done(c);
    end
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

// File: huff_compress_top.f
+incdir+.
huff_pkg.sv
chunk_packer.sv
symbol_store.sv
code_length_builder.sv
canonical_codebook.sv
bit_emitter.sv
huff_compress_top.sv
tb_huff_compress.sv
